/* design/cpu_isa_pkg.sv */
// instruction-set widths, field positions, opcode and funct enums
package cpu_isa_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_VECTOR = 32'hBFC0_0000;

    localparam int OP_LSB  = 26;
    localparam int RS_LSB  = 21;
    localparam int RT_LSB  = 16;
    localparam int RD_LSB  = 11;
    localparam int IMM_LSB = 0;
    localparam int IMM_W   = 16;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

endpackage

/* design/cpu_ctrl_pkg.sv */
// pipeline control enums and step/enable constants
package cpu_ctrl_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic {SRC_B_REG, SRC_B_IMM} src_b_e;

    typedef enum logic {IMM_SIGN, IMM_ZERO} imm_ext_e;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_e;

    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef enum logic {WB_ALU, WB_LOAD} wb_sel_e;

    localparam int PC_STEP = 4;

    localparam logic [3:0] WEN_ALL = 4'b1111;

endpackage

/* design/fetch_unit.sv */
// PC register, next-PC select and IF/ID register
`timescale 1ns/1ps

module fetch_unit
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            stall_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] target_i,
    input  logic [XLEN-1:0] inst_sram_rdata_i,
    output logic            inst_sram_en_o,
    output logic [XLEN-1:0] inst_sram_addr_o,
    output logic [XLEN-1:0] id_instr_o,
    output logic [XLEN-1:0] id_pc_o
);

    logic [XLEN-1:0] pc_q;
    logic            run_q;     // first cycle out of reset
    logic            fetched_q; // sram output holds a real word

    assign inst_sram_addr_o = redirect_i ? target_i : pc_q + PC_STEP;
    assign inst_sram_en_o   = run_q & ~stall_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_VECTOR - PC_STEP;
            run_q      <= 1'b0;
            fetched_q  <= 1'b0;
            id_instr_o <= '0;
            id_pc_o    <= '0;
        end else begin
            run_q     <= 1'b1;
            fetched_q <= fetched_q | run_q;
            if (inst_sram_en_o) pc_q <= inst_sram_addr_o;
            if (!stall_i) begin
                // wrong-path word behind the delay slot is dropped
                id_instr_o <= (redirect_i || !fetched_q) ? '0 : inst_sram_rdata_i;
                id_pc_o    <= pc_q;
            end
        end
    end

endmodule

/* design/insn_decoder.sv */
// combinational decode of an instruction word into control fields
`timescale 1ns/1ps

module insn_decoder
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic [XLEN-1:0]   instr_i,
    output alu_op_e           alu_op_o,
    output src_b_e            src_b_o,
    output imm_ext_e          imm_ext_o,
    output branch_e           branch_o,
    output wb_sel_e           wb_sel_o,
    output logic              reg_we_o,
    output logic [REG_AW-1:0] dst_o,
    output logic              mem_read_o,
    output logic              mem_write_o,
    output logic              reads_rt_o
);

    opcode_e op;
    funct_e  fn;
    logic    we_raw;

    assign op = opcode_e'(instr_i[OP_LSB +: 6]);
    assign fn = funct_e'(instr_i[5:0]);

    assign dst_o    = (op == OP_SPECIAL) ? instr_i[RD_LSB +: REG_AW] : instr_i[RT_LSB +: REG_AW];
    assign reg_we_o = we_raw && (dst_o != '0); // $0 never written

    always_comb begin
        alu_op_o    = ALU_ADD;
        src_b_o     = SRC_B_IMM;
        imm_ext_o   = IMM_SIGN;
        branch_o    = BR_NONE;
        wb_sel_o    = WB_ALU;
        we_raw      = 1'b0;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        reads_rt_o  = 1'b0;
        case (op)
            OP_SPECIAL: begin
                src_b_o    = SRC_B_REG;
                reads_rt_o = 1'b1;
                we_raw     = 1'b1;
                case (fn)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    default: we_raw   = 1'b0; // unknown funct is a nop
                endcase
            end
            OP_ADDIU: we_raw = 1'b1;
            OP_ORI: begin
                alu_op_o  = ALU_OR;
                imm_ext_o = IMM_ZERO;
                we_raw    = 1'b1;
            end
            OP_LUI: begin
                alu_op_o = ALU_LUI;
                we_raw   = 1'b1;
            end
            OP_LW: begin
                wb_sel_o   = WB_LOAD;
                mem_read_o = 1'b1;
                we_raw     = 1'b1;
            end
            OP_SW: begin
                mem_write_o = 1'b1;
                reads_rt_o  = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                branch_o   = (op == OP_BEQ) ? BR_EQ : BR_NE;
                src_b_o    = SRC_B_REG;
                reads_rt_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* design/reg_file.sv */
// 32x32 register file, two async reads with write bypass, one write port
`timescale 1ns/1ps

module reg_file
    import cpu_isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [REG_AW-1:0] ra_i,
    input  logic [REG_AW-1:0] rb_i,
    input  logic              we_i,
    input  logic [REG_AW-1:0] wa_i,
    input  logic [XLEN-1:0]   wd_i,
    output logic [XLEN-1:0]   rd_a_o,
    output logic [XLEN-1:0]   rd_b_o
);

    logic [XLEN-1:0] regs_q [2**REG_AW];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**REG_AW; i++) regs_q[i] <= '0;
        end else if (we_i && wa_i != '0) begin
            regs_q[wa_i] <= wd_i;
        end
    end

    // writeback in flight wins over the stored value
    assign rd_a_o = (ra_i == '0) ? '0 : (we_i && wa_i == ra_i) ? wd_i : regs_q[ra_i];
    assign rd_b_o = (rb_i == '0) ? '0 : (we_i && wa_i == rb_i) ? wd_i : regs_q[rb_i];

endmodule

/* design/decode_stage.sv */
// operand read, immediate extend, load-use detect and ID/EXE register
`timescale 1ns/1ps

module decode_stage
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [XLEN-1:0]   id_instr_i,
    input  logic [XLEN-1:0]   id_pc_i,
    input  logic              redirect_i,
    input  logic              wb_we_i,
    input  logic [REG_AW-1:0] wb_dst_i,
    input  logic [XLEN-1:0]   wb_data_i,
    output logic              stall_o,
    output alu_op_e           ex_alu_op_o,
    output src_b_e            ex_src_b_o,
    output branch_e           ex_branch_o,
    output wb_sel_e           ex_wb_sel_o,
    output logic              ex_reg_we_o,
    output logic [REG_AW-1:0] ex_dst_o,
    output logic              ex_mem_read_o,
    output logic              ex_mem_write_o,
    output logic [REG_AW-1:0] ex_rs_o,
    output logic [REG_AW-1:0] ex_rt_o,
    output logic [XLEN-1:0]   ex_a_o,
    output logic [XLEN-1:0]   ex_b_o,
    output logic [XLEN-1:0]   ex_imm_o,
    output logic [XLEN-1:0]   ex_pc_o
);

    alu_op_e           alu_op;
    src_b_e            src_b;
    imm_ext_e          imm_ext;
    branch_e           branch;
    wb_sel_e           wb_sel;
    logic              reg_we, mem_read, mem_write, reads_rt, bubble;
    logic [REG_AW-1:0] dst, rs, rt;
    logic [XLEN-1:0]   rd_a, rd_b, imm;
    logic [IMM_W-1:0]  imm16;

    assign rs    = id_instr_i[RS_LSB +: REG_AW];
    assign rt    = id_instr_i[RT_LSB +: REG_AW];
    assign imm16 = id_instr_i[IMM_LSB +: IMM_W];
    assign imm   = (imm_ext == IMM_ZERO) ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};

    insn_decoder u_dec (
        .instr_i(id_instr_i), .alu_op_o(alu_op), .src_b_o(src_b), .imm_ext_o(imm_ext),
        .branch_o(branch), .wb_sel_o(wb_sel), .reg_we_o(reg_we), .dst_o(dst),
        .mem_read_o(mem_read), .mem_write_o(mem_write), .reads_rt_o(reads_rt)
    );

    reg_file u_rf (
        .clk(clk), .rst_n_i(rst_n_i), .ra_i(rs), .rb_i(rt), .we_i(wb_we_i),
        .wa_i(wb_dst_i), .wd_i(wb_data_i), .rd_a_o(rd_a), .rd_b_o(rd_b)
    );

    // load in EXE feeding this instruction
    assign stall_o = ex_mem_read_o && ex_reg_we_o &&
                     (ex_dst_o == rs || (reads_rt && ex_dst_o == rt));
    assign bubble  = stall_o && !redirect_i; // delay slot always advances

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_branch_o    <= BR_NONE;
            ex_reg_we_o    <= 1'b0;
            ex_mem_read_o  <= 1'b0;
            ex_mem_write_o <= 1'b0;
        end else begin
            ex_branch_o    <= bubble ? BR_NONE : branch;
            ex_reg_we_o    <= reg_we && !bubble;
            ex_mem_read_o  <= mem_read && !bubble;
            ex_mem_write_o <= mem_write && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op_o <= alu_op;
        ex_src_b_o  <= src_b;
        ex_wb_sel_o <= wb_sel;
        ex_dst_o    <= dst;
        ex_rs_o     <= rs;
        ex_rt_o     <= rt;
        ex_a_o      <= rd_a;
        ex_b_o      <= rd_b;
        ex_imm_o    <= imm;
        ex_pc_o     <= id_pc_i;
    end

endmodule

/* design/execute_stage.sv */
// forwarding muxes, ALU, branch resolve, data SRAM request, EXE/MEM register
`timescale 1ns/1ps

module execute_stage
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  alu_op_e           ex_alu_op_i,
    input  src_b_e            ex_src_b_i,
    input  branch_e           ex_branch_i,
    input  wb_sel_e           ex_wb_sel_i,
    input  logic              ex_reg_we_i,
    input  logic [REG_AW-1:0] ex_dst_i,
    input  logic              ex_mem_read_i,
    input  logic              ex_mem_write_i,
    input  logic [REG_AW-1:0] ex_rs_i,
    input  logic [REG_AW-1:0] ex_rt_i,
    input  logic [XLEN-1:0]   ex_a_i,
    input  logic [XLEN-1:0]   ex_b_i,
    input  logic [XLEN-1:0]   ex_imm_i,
    input  logic [XLEN-1:0]   ex_pc_i,
    input  logic [XLEN-1:0]   mem_alu_i,
    input  logic [REG_AW-1:0] mem_dst_i,
    input  logic              mem_we_i,
    input  logic [REG_AW-1:0] wb_dst_i,
    input  logic              wb_we_i,
    input  logic [XLEN-1:0]   wb_data_i,
    output logic              redirect_o,
    output logic [XLEN-1:0]   target_o,
    output logic              data_sram_en_o,
    output logic [3:0]        data_sram_wen_o,
    output logic [XLEN-1:0]   data_sram_addr_o,
    output logic [XLEN-1:0]   data_sram_wdata_o,
    output logic [XLEN-1:0]   mem_alu_o,
    output logic [REG_AW-1:0] mem_dst_o,
    output logic              mem_we_o,
    output wb_sel_e           mem_wb_sel_o,
    output logic [XLEN-1:0]   mem_pc_o
);

    fwd_sel_e        fwd_a, fwd_b;
    logic [XLEN-1:0] op_a, op_b, alu_b, alu_y;

    function automatic fwd_sel_e pick(input logic [REG_AW-1:0] src);
        if (mem_we_i && mem_dst_i == src) return FWD_MEM; // younger result first
        if (wb_we_i && wb_dst_i == src) return FWD_WB;
        return FWD_REG;
    endfunction

    assign fwd_a = pick(ex_rs_i);
    assign fwd_b = pick(ex_rt_i);

    assign op_a  = (fwd_a == FWD_MEM) ? mem_alu_i : (fwd_a == FWD_WB) ? wb_data_i : ex_a_i;
    assign op_b  = (fwd_b == FWD_MEM) ? mem_alu_i : (fwd_b == FWD_WB) ? wb_data_i : ex_b_i;
    assign alu_b = (ex_src_b_i == SRC_B_IMM) ? ex_imm_i : op_b;

    always_comb begin
        case (ex_alu_op_i)
            ALU_SUB: alu_y = op_a - alu_b;
            ALU_AND: alu_y = op_a & alu_b;
            ALU_OR:  alu_y = op_a | alu_b;
            ALU_SLT: alu_y = {31'b0, $signed(op_a) < $signed(alu_b)};
            ALU_LUI: alu_y = {alu_b[15:0], 16'b0};
            default: alu_y = op_a + alu_b;
        endcase
    end

    assign redirect_o = (ex_branch_i == BR_EQ && op_a == op_b) ||
                        (ex_branch_i == BR_NE && op_a != op_b);
    assign target_o   = ex_pc_i + PC_STEP + {ex_imm_i[XLEN-3:0], 2'b00}; // from delay slot

    assign data_sram_en_o    = ex_mem_read_i | ex_mem_write_i;
    assign data_sram_wen_o   = ex_mem_write_i ? WEN_ALL : 4'b0000;
    assign data_sram_addr_o  = alu_y;
    assign data_sram_wdata_o = op_b;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) mem_we_o <= 1'b0;
        else          mem_we_o <= ex_reg_we_i;
    end

    always_ff @(posedge clk) begin
        mem_alu_o    <= alu_y;
        mem_dst_o    <= ex_dst_i;
        mem_wb_sel_o <= ex_wb_sel_i;
        mem_pc_o     <= ex_pc_i;
    end

endmodule

/* design/mem_wb_stage.sv */
// MEM/WB register, writeback select and debug trace
`timescale 1ns/1ps

module mem_wb_stage
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [XLEN-1:0]   mem_alu_i,
    input  logic [REG_AW-1:0] mem_dst_i,
    input  logic              mem_we_i,
    input  wb_sel_e           mem_wb_sel_i,
    input  logic [XLEN-1:0]   mem_pc_i,
    input  logic [XLEN-1:0]   data_sram_rdata_i,
    output logic              wb_we_o,
    output logic [REG_AW-1:0] wb_dst_o,
    output logic [XLEN-1:0]   wb_data_o,
    output logic [XLEN-1:0]   debug_wb_pc_o,
    output logic [3:0]        debug_wb_rf_wen_o,
    output logic [REG_AW-1:0] debug_wb_rf_wnum_o,
    output logic [XLEN-1:0]   debug_wb_rf_wdata_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) wb_we_o <= 1'b0;
        else          wb_we_o <= mem_we_i;
    end

    always_ff @(posedge clk) begin
        wb_data_o     <= (mem_wb_sel_i == WB_LOAD) ? data_sram_rdata_i : mem_alu_i;
        wb_dst_o      <= mem_dst_i;
        debug_wb_pc_o <= mem_pc_i;
    end

    assign debug_wb_rf_wen_o   = wb_we_o ? WEN_ALL : 4'b0000;
    assign debug_wb_rf_wnum_o  = wb_dst_o;
    assign debug_wb_rf_wdata_o = wb_data_o;

endmodule

/* design/mycpu_top.sv */
// core top level connecting the pipeline stages to SRAM and trace ports
`timescale 1ns/1ps

module mycpu_top
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [XLEN-1:0]   inst_sram_rdata_i,
    input  logic [XLEN-1:0]   data_sram_rdata_i,
    output logic              inst_sram_en_o,
    output logic [XLEN-1:0]   inst_sram_addr_o,
    output logic              data_sram_en_o,
    output logic [3:0]        data_sram_wen_o,
    output logic [XLEN-1:0]   data_sram_addr_o,
    output logic [XLEN-1:0]   data_sram_wdata_o,
    output logic [XLEN-1:0]   debug_wb_pc_o,
    output logic [3:0]        debug_wb_rf_wen_o,
    output logic [REG_AW-1:0] debug_wb_rf_wnum_o,
    output logic [XLEN-1:0]   debug_wb_rf_wdata_o
);

    logic              stall, redirect, ex_reg_we, ex_mem_read, ex_mem_write;
    logic              mem_we, wb_we;
    logic [XLEN-1:0]   target, id_instr, id_pc, ex_a, ex_b, ex_imm, ex_pc;
    logic [XLEN-1:0]   mem_alu, mem_pc, wb_data;
    logic [REG_AW-1:0] ex_dst, ex_rs, ex_rt, mem_dst, wb_dst;
    alu_op_e           ex_alu_op;
    src_b_e            ex_src_b;
    branch_e           ex_branch;
    wb_sel_e           ex_wb_sel, mem_wb_sel;

    fetch_unit u_fetch (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall), .redirect_i(redirect),
        .target_i(target), .inst_sram_rdata_i(inst_sram_rdata_i),
        .inst_sram_en_o(inst_sram_en_o), .inst_sram_addr_o(inst_sram_addr_o),
        .id_instr_o(id_instr), .id_pc_o(id_pc)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n_i(rst_n_i), .id_instr_i(id_instr), .id_pc_i(id_pc),
        .redirect_i(redirect), .wb_we_i(wb_we), .wb_dst_i(wb_dst), .wb_data_i(wb_data),
        .stall_o(stall), .ex_alu_op_o(ex_alu_op), .ex_src_b_o(ex_src_b),
        .ex_branch_o(ex_branch), .ex_wb_sel_o(ex_wb_sel), .ex_reg_we_o(ex_reg_we),
        .ex_dst_o(ex_dst), .ex_mem_read_o(ex_mem_read), .ex_mem_write_o(ex_mem_write),
        .ex_rs_o(ex_rs), .ex_rt_o(ex_rt), .ex_a_o(ex_a), .ex_b_o(ex_b),
        .ex_imm_o(ex_imm), .ex_pc_o(ex_pc)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n_i(rst_n_i), .ex_alu_op_i(ex_alu_op), .ex_src_b_i(ex_src_b),
        .ex_branch_i(ex_branch), .ex_wb_sel_i(ex_wb_sel), .ex_reg_we_i(ex_reg_we),
        .ex_dst_i(ex_dst), .ex_mem_read_i(ex_mem_read), .ex_mem_write_i(ex_mem_write),
        .ex_rs_i(ex_rs), .ex_rt_i(ex_rt), .ex_a_i(ex_a), .ex_b_i(ex_b),
        .ex_imm_i(ex_imm), .ex_pc_i(ex_pc), .mem_alu_i(mem_alu), .mem_dst_i(mem_dst),
        .mem_we_i(mem_we), .wb_dst_i(wb_dst), .wb_we_i(wb_we), .wb_data_i(wb_data),
        .redirect_o(redirect), .target_o(target), .data_sram_en_o(data_sram_en_o),
        .data_sram_wen_o(data_sram_wen_o), .data_sram_addr_o(data_sram_addr_o),
        .data_sram_wdata_o(data_sram_wdata_o), .mem_alu_o(mem_alu), .mem_dst_o(mem_dst),
        .mem_we_o(mem_we), .mem_wb_sel_o(mem_wb_sel), .mem_pc_o(mem_pc)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk), .rst_n_i(rst_n_i), .mem_alu_i(mem_alu), .mem_dst_i(mem_dst),
        .mem_we_i(mem_we), .mem_wb_sel_i(mem_wb_sel), .mem_pc_i(mem_pc),
        .data_sram_rdata_i(data_sram_rdata_i), .wb_we_o(wb_we), .wb_dst_o(wb_dst),
        .wb_data_o(wb_data), .debug_wb_pc_o(debug_wb_pc_o),
        .debug_wb_rf_wen_o(debug_wb_rf_wen_o), .debug_wb_rf_wnum_o(debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

endmodule

/* include/tb_program.svh */
// test program words and expected writeback trace
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN = 19;

localparam logic [31:0] PROG [PROG_LEN] = '{
    32'h3401_0010, 32'h2422_0005, 32'h0022_1821, 32'h3C04_1234, // ori addiu addu lui
    32'h0083_2825, 32'h00A1_3023, 32'h0022_382A, 32'hAC05_0000, // or subu slt sw
    32'h8C08_0000, 32'h0101_4821, 32'h8C0A_0004, 32'h2400_0007, // lw, use, lw preload, $0
    32'h0009_5824, 32'h1021_0002, 32'h240C_0001, 32'h240D_0001, // and, beq, slot, skipped
    32'h1421_0002, 32'h240E_0002, 32'h244F_FFFF                 // bne falls through
};

localparam int TRACE_LEN = 14;

localparam logic [31:0] TRACE_PC [TRACE_LEN] = '{
    32'hBFC0_0000, 32'hBFC0_0004, 32'hBFC0_0008, 32'hBFC0_000C, 32'hBFC0_0010,
    32'hBFC0_0014, 32'hBFC0_0018, 32'hBFC0_0020, 32'hBFC0_0024, 32'hBFC0_0028,
    32'hBFC0_0030, 32'hBFC0_0038, 32'hBFC0_0044, 32'hBFC0_0048
};

localparam logic [4:0] TRACE_WNUM [TRACE_LEN] = '{
    5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd11, 5'd12, 5'd14, 5'd15
};

// a preload entry holds the data word index instead of the value
localparam logic [31:0] TRACE_WDATA [TRACE_LEN] = '{
    32'h0000_0010, 32'h0000_0015, 32'h0000_0025, 32'h1234_0000, 32'h1234_0025,
    32'h1234_0015, 32'h0000_0001, 32'h1234_0025, 32'h1234_0035, 32'h0000_0001,
    32'h0000_0000, 32'h0000_0001, 32'h0000_0002, 32'h0000_0014
};

localparam logic [TRACE_LEN-1:0] TRACE_PRELOAD = 14'b00_0010_0000_0000;

`endif

/* tests/tb_mycpu.sv */
// testbench for mycpu_top with SRAM models, trace checker and watchdog
`timescale 1ns/1ps

module tb_mycpu
    import cpu_isa_pkg::*;
();

    `include "tb_program.svh"

    localparam int DMEM_WORDS   = 256;
    localparam int CYCLE_BUDGET = PROG_LEN * 3 + 20;
    localparam int DRAIN_CYCLES = 8; // room for a stray trace entry

    logic              clk;
    logic              rst_n_i;
    logic [31:0]       inst_sram_rdata_i;
    logic [31:0]       data_sram_rdata_i;
    logic              inst_sram_en_o;
    logic [31:0]       inst_sram_addr_o;
    logic              data_sram_en_o;
    logic [3:0]        data_sram_wen_o;
    logic [31:0]       data_sram_addr_o;
    logic [31:0]       data_sram_wdata_o;
    logic [31:0]       debug_wb_pc_o;
    logic [3:0]        debug_wb_rf_wen_o;
    logic [4:0]        debug_wb_rf_wnum_o;
    logic [31:0]       debug_wb_rf_wdata_o;

    logic [31:0] data_mem [DMEM_WORDS];
    logic [31:0] preload  [DMEM_WORDS]; // untouched copy for expected loads
    logic        ireq_en, dreq_en;
    logic [31:0] ireq_addr, dreq_addr, dreq_wdata;
    logic [3:0]  dreq_wen;
    integer      seed;
    int          trace_idx;
    int          value_errors;
    int          trace_errors;
    int          cycles_out_of_reset;

    mycpu_top i_dut (
        .clk(clk), .rst_n_i(rst_n_i),
        .inst_sram_rdata_i(inst_sram_rdata_i), .data_sram_rdata_i(data_sram_rdata_i),
        .inst_sram_en_o(inst_sram_en_o), .inst_sram_addr_o(inst_sram_addr_o),
        .data_sram_en_o(data_sram_en_o), .data_sram_wen_o(data_sram_wen_o),
        .data_sram_addr_o(data_sram_addr_o), .data_sram_wdata_o(data_sram_wdata_o),
        .debug_wb_pc_o(debug_wb_pc_o), .debug_wb_rf_wen_o(debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o(debug_wb_rf_wnum_o), .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] program_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_VECTOR) >> 2;
        return (idx < PROG_LEN) ? PROG[idx] : 32'h0000_0000; // nop past the end
    endfunction

    function automatic logic [31:0] expected_wdata(input int k);
        return TRACE_PRELOAD[k] ? preload[TRACE_WDATA[k]] : TRACE_WDATA[k];
    endfunction

    task automatic print_summary();
        $display("summary: %0d of %0d trace entries, %0d value errors, %0d trace errors",
                 trace_idx, TRACE_LEN, value_errors, trace_errors);
    endtask

    // requests are stable mid-cycle
    always @(negedge clk) begin
        ireq_en    <= inst_sram_en_o;
        ireq_addr  <= inst_sram_addr_o;
        dreq_en    <= data_sram_en_o;
        dreq_wen   <= data_sram_wen_o;
        dreq_addr  <= data_sram_addr_o;
        dreq_wdata <= data_sram_wdata_o;
    end

    // both SRAMs answer one cycle after the request
    always @(posedge clk) begin
        #1;
        if (ireq_en) inst_sram_rdata_i = program_word(ireq_addr); // holds when idle
        if (dreq_en) begin
            if (dreq_wen != 4'b0000) begin
                for (int b = 0; b < 4; b++) begin
                    if (dreq_wen[b]) data_mem[dreq_addr[9:2]][8*b +: 8] = dreq_wdata[8*b +: 8];
                end
            end else begin
                data_sram_rdata_i = data_mem[dreq_addr[9:2]];
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n_i || cycles_out_of_reset < 2) begin
            assert (data_sram_en_o == 1'b0 && debug_wb_rf_wen_o == 4'b0000) else begin
                $display("ERR %0t: idle outputs active near reset, en %b wen %b",
                         $time, data_sram_en_o, debug_wb_rf_wen_o);
                value_errors++;
            end
        end
        if (rst_n_i) cycles_out_of_reset++;
        if (rst_n_i && debug_wb_rf_wen_o != 4'b0000) begin
            if (trace_idx >= TRACE_LEN) begin
                $display("extra writeback at %0t beyond the expected trace, pc %h reg %0d",
                         $time, debug_wb_pc_o, debug_wb_rf_wnum_o);
                trace_errors++;
            end else begin
                assert (debug_wb_rf_wen_o == 4'b1111 &&
                        debug_wb_pc_o == TRACE_PC[trace_idx] &&
                        debug_wb_rf_wnum_o == TRACE_WNUM[trace_idx] &&
                        debug_wb_rf_wdata_o == expected_wdata(trace_idx)) else begin
                    $display("ERR %0t: entry %0d wen %b pc %h r%0d=%h, want pc %h r%0d=%h",
                             $time, trace_idx, debug_wb_rf_wen_o, debug_wb_pc_o,
                             debug_wb_rf_wnum_o, debug_wb_rf_wdata_o, TRACE_PC[trace_idx],
                             TRACE_WNUM[trace_idx], expected_wdata(trace_idx));
                    value_errors++;
                end
            end
            trace_idx++;
        end
    end

    initial begin
        clk                 = 1'b0;
        rst_n_i             = 1'b0;
        inst_sram_rdata_i   = '0;
        data_sram_rdata_i   = '0;
        trace_idx           = 0;
        value_errors        = 0;
        trace_errors        = 0;
        cycles_out_of_reset = 0;
        seed                = 23724;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            data_mem[i] = $random(seed);
            preload[i]  = data_mem[i];
        end
        repeat (10) @(posedge clk);
        #1 rst_n_i = 1'b1;
        while (trace_idx < TRACE_LEN) @(posedge clk);
        repeat (DRAIN_CYCLES) @(posedge clk);
        print_summary();
        if (value_errors == 0 && trace_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // budget counts from the end of reset
    initial begin
        repeat (10 + CYCLE_BUDGET) @(posedge clk);
        $display("timeout after %0d cycles, the writeback trace was incomplete",
                 CYCLE_BUDGET);
        print_summary();
        $display("Regression failed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/fetch_unit.sv
design/insn_decoder.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/mycpu_top.sv
tests/tb_mycpu.sv
